//--- bench/smc_mem_model.sv
//------------------
// Behavioural async SRAM for the controller testbench
// Stores writes, drives read data while CS and OE are low and
// measures strobe and chip select widths in clock cycles.
// A width is published with a one-cycle end pulse
//------------------

`timescale 1ns/1ps

module smc_mem_model
  import smc_pkg::*;
(
  input  logic      sys_clk22,
  input  logic      mem_cs_n,
  input  logic      mem_oe_n,
  input  logic      mem_we_n,
  input  smc_addr_t mem_addr,
  input  smc_data_t mem_wdata,
  output smc_data_t mem_rdata,
  output logic      strobe_end,    // OE or WE just went high
  output int        strobe_width,  // Cycles of that strobe
  output logic      cs_end,        // CS just went high
  output int        cs_width       // Cycles of that CS pulse
);

  smc_data_t mem [0:65535];
  int        strobe_run = 0;  // Strobe cycles so far
  int        cs_run     = 0;  // CS cycles so far

  initial
  begin
    strobe_end   = 1'b0;
    cs_end       = 1'b0;
    strobe_width = 0;
    cs_width     = 0;
    for (int i = 0; i < 65536; i++)
      mem[i[15:0]] = i[15:0] ^ 16'h3c5a;  // Fill from the full address
  end

  // Floating bus reads back as all ones
  assign mem_rdata = (!mem_cs_n && !mem_oe_n) ? mem[mem_addr] : 16'hffff;

  //------------------
  // Write and width monitor
  //------------------
  always @(posedge sys_clk22)
  begin
    strobe_end <= 1'b0;
    cs_end     <= 1'b0;
    if (!mem_cs_n && !mem_we_n)
      mem[mem_addr] <= mem_wdata;  // Address and data held through RW
    if (!mem_oe_n || !mem_we_n)
      strobe_run <= strobe_run + 1;
    else if (strobe_run != 0)
    begin
      strobe_width <= strobe_run;  // Strobe over, report it
      strobe_end   <= 1'b1;
      strobe_run   <= 0;
    end
    if (!mem_cs_n)
      cs_run <= cs_run + 1;
    else if (cs_run != 0)
    begin
      cs_width <= cs_run;
      cs_end   <= 1'b1;
      cs_run   <= 0;
    end
  end

endmodule

//--- bench/smc_tb.sv
//------------------
// Testbench for the lite static memory controller
// Runs corner and random timings through single accesses,
// same-direction chains and direction changes. Concurrent
// assertions compare responses and bus widths with a
// scoreboard built from the request stream
// Direction changes get a new leading edge length for the
// second access, which only a fresh store cycle picks up
//------------------

`timescale 1ns/1ps

module smc_tb
  import smc_pkg::*;
();

  logic        sys_clk22     = 1'b0;
  logic        n_sys_reset22 = 1'b1;
  logic        req_valid;
  smc_req_t    req;
  smc_timing_t timing;
  logic        rsp_valid;
  smc_rsp_t    rsp;
  logic        idle;
  logic        mem_cs_n;
  logic        mem_oe_n;
  logic        mem_we_n;
  smc_addr_t   mem_addr;
  smc_data_t   mem_wdata;
  smc_data_t   mem_rdata;
  logic        strobe_end;
  int          strobe_width;
  logic        cs_end;
  int          cs_width;

  //------------------
  // Scoreboard state
  //------------------
  smc_data_t   shadow [0:65535];  // Last data written per address
  smc_rsp_t    exp_rsp [0:1023];  // Expected response per request
  logic [9:0]  n_issued = '0;
  logic [9:0]  n_done   = '0;
  logic        req_seen = 1'b0;   // First request strobe sampled
  int          exp_strobe = 0;    // OE or WE width of ws + 1
  int          exp_cs     = 0;    // CS width of the next pulse
  int          cs_single  = 0;    // CS width of one isolated access
  int          seed = 32'hefd4_f36b;
  string       test_name = "reset";

  always #10 sys_clk22 = ~sys_clk22;  // 50 MHz

  smc_top DUT (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .req_valid     (req_valid),
    .req           (req),
    .timing        (timing),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .idle          (idle),
    .mem_cs_n      (mem_cs_n),
    .mem_oe_n      (mem_oe_n),
    .mem_we_n      (mem_we_n),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata)
  );

  smc_mem_model u_mem (
    .sys_clk22    (sys_clk22),
    .mem_cs_n     (mem_cs_n),
    .mem_oe_n     (mem_oe_n),
    .mem_we_n     (mem_we_n),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_rdata    (mem_rdata),
    .strobe_end   (strobe_end),
    .strobe_width (strobe_width),
    .cs_end       (cs_end),
    .cs_width     (cs_width)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  always @(posedge sys_clk22)
  begin
    if (rsp_valid)
      n_done <= n_done + 10'd1;  // Responses come back in order
    if (req_valid)
      req_seen <= 1'b1;
  end

  //------------------
  // Checks
  //------------------
  // Quiet bus until the first request
  reset_check: assert property (@(posedge sys_clk22) disable iff (!n_sys_reset22)
    !req_seen |-> ({idle, mem_cs_n, mem_oe_n, mem_we_n, rsp_valid} == 5'b11110))
  else
    stop_run($sformatf("FAIL %s expected %b actual %b", test_name, 5'b11110,
      $sampled({idle, mem_cs_n, mem_oe_n, mem_we_n, rsp_valid})));

  rsp_check: assert property (@(posedge sys_clk22) disable iff (!n_sys_reset22)
    rsp_valid |-> (rsp == exp_rsp[n_done]))
  else
    stop_run($sformatf("FAIL %s expected %h actual %h", test_name,
      exp_rsp[$sampled(n_done)], $sampled(rsp)));

  strobe_check: assert property (@(posedge sys_clk22) disable iff (!n_sys_reset22)
    strobe_end |-> (strobe_width == exp_strobe))
  else
    stop_run($sformatf("FAIL %s expected %0d actual %0d", test_name,
      exp_strobe, $sampled(strobe_width)));

  // Catches CS gaps in chains and missing store cycles
  cs_check: assert property (@(posedge sys_clk22) disable iff (!n_sys_reset22)
    cs_end |-> (cs_width == exp_cs))
  else
    stop_run($sformatf("FAIL %s expected %0d actual %0d", test_name,
      exp_cs, $sampled(cs_width)));

  //------------------
  // Stimulus tasks
  //------------------
  task automatic set_timing(input smc_edge_t csle, input smc_wait_t ws,
                            input smc_edge_t cste, input smc_edge_t oete);
    timing.csle = csle;
    timing.ws   = ws;
    timing.cste = cste;
    timing.oete = oete;
    exp_strobe  = int'(ws) + 1;
    cs_single   = int'(csle) + int'(ws) + 1 + int'(cste);
  endtask

  // Chains need a float cycle so strobes stay apart
  task automatic random_timing(input logic chained);
    logic [31:0] r;
    smc_edge_t   cste;
    smc_edge_t   oete;
    r    = $random(seed);
    cste = (chained && r[11:10] == 2'd0) ? 2'd1 : r[11:10];
    oete = ({6'd0, r[13:12]} > r[9:2]) ? r[3:2] : r[13:12];  // Window inside strobe
    set_timing(r[1:0], r[9:2], cste, oete);
  endtask

  task automatic issue_req(input logic write, input smc_addr_t addr, input smc_data_t data);
    req_valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = data;
    exp_rsp[n_issued].write = write;
    if (write)
    begin
      shadow[addr] = data;
      exp_rsp[n_issued].rdata = '0;  // Writes answer with zero
    end
    else
      exp_rsp[n_issued].rdata = shadow[addr];
    n_issued = n_issued + 10'd1;
    @(posedge sys_clk22);
    #2;
    req_valid = 1'b0;
  endtask

  // New LE length once the first access has stored its settings
  // The second CS pulse only shows it after a fresh store cycle
  task automatic change_le_length();
    int        cycles;
    smc_edge_t csle_new;
    cycles   = 0;
    csle_new = timing.csle + 2'd1;
    @(posedge sys_clk22);  // First access past its store cycle
    #2;
    set_timing(csle_new, timing.ws, timing.cste, timing.oete);
    while (!cs_end)
    begin
      @(posedge sys_clk22);
      #2;
      cycles = cycles + 1;
      if (cycles > 1000)
        stop_run("timeout waiting for the first chip select pulse to end");
    end
    @(posedge sys_clk22);  // First pulse checked with the old width
    #2;
    exp_cs = cs_single;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (n_done != n_issued || !idle)
    begin
      @(posedge sys_clk22);
      #2;
      cycles = cycles + 1;
      if (cycles > 2000)
        stop_run("timeout waiting for the controller to finish its accesses");
    end
    repeat (3) @(posedge sys_clk22);  // Monitor pulses drain
    #2;
  endtask

  task automatic run_single(input logic write, input smc_addr_t addr, input smc_data_t data);
    exp_cs = cs_single;
    issue_req(write, addr, data);
    wait_done();
  endtask

  task automatic run_pair(input logic w1, input smc_addr_t a1, input smc_data_t d1,
                          input logic w2, input smc_addr_t a2, input smc_data_t d2);
    exp_cs = (w1 == w2) ? 2 * cs_single : cs_single;  // One CS pulse for same direction
    issue_req(w1, a1, d1);
    issue_req(w2, a2, d2);  // Waits while the first runs
    if (w1 != w2)
      change_le_length();
    wait_done();
  endtask

  //------------------
  // Main sequence
  //------------------
  initial
  begin
    logic [31:0] r1;
    logic [31:0] r2;
    n_sys_reset22 = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    timing        = '0;
    repeat (16) @(posedge sys_clk22);
    #2;
    n_sys_reset22 = 1'b1;
    repeat (5) @(posedge sys_clk22);  // Idle window for the reset check
    #2;

    test_name = "corner_zero";
    set_timing(2'd0, 8'd0, 2'd0, 2'd0);
    run_single(1'b1, 16'h0001, 16'h1234);
    run_single(1'b0, 16'h0001, 16'h0000);
    test_name = "corner_max";
    set_timing(2'd3, 8'd255, 2'd3, 2'd3);
    run_single(1'b1, 16'hffff, 16'hbeef);
    run_single(1'b0, 16'hffff, 16'h0000);

    for (int iter = 0; iter < 24; iter++)
    begin
      r1 = $random(seed);
      r2 = $random(seed);
      test_name = "single";
      random_timing(1'b0);
      run_single(1'b1, r1[15:0], r1[31:16]);
      run_single(1'b0, r1[15:0], 16'h0000);
      test_name = "same_dir";
      random_timing(1'b1);
      run_pair(1'b1, r1[15:0], r2[15:0], 1'b1, r2[31:16], r1[31:16]);
      run_pair(1'b0, r1[15:0], 16'h0000, 1'b0, r2[31:16], 16'h0000);
      test_name = "dir_change";  // Read after write goes through store
      run_pair(1'b1, r2[15:0], r2[31:16], 1'b0, r2[15:0], 16'h0000);
    end

    if (n_done == n_issued)
    begin
      $display("test passed");
      $finish;
    end
    else
      stop_run("response count does not match the request count");
  end

endmodule

//--- files.f
source/smc_pkg.sv
source/smc_access_decode.sv
source/smc_phase_counters.sv
source/smc_state.sv
source/smc_read_capture.sv
source/smc_top.sv
bench/smc_mem_model.sv
bench/smc_tb.sv

//--- run.sh
#!/bin/sh
# Build the controller testbench with Verilator, run it and look for the pass line
verilator --binary --assert --top-module smc_tb -f files.f -o smc_sim \
  && ./obj_dir/smc_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

//--- source/smc_access_decode.sv
//------------------
// Host request capture
// Holds one waiting access between the host strobe and the
// cycle the state machine takes it. No back-pressure, so a
// strobe into a full entry is a host error
//------------------

`timescale 1ns/1ps

module smc_access_decode
  import smc_pkg::*;
(
  input  logic     sys_clk22,
  input  logic     n_sys_reset22,

  // Host side
  input  logic     req_valid,   // One-cycle request strobe
  input  smc_req_t req,         // Request payload

  // State machine side
  input  logic     accept,      // Waiting access taken this cycle
  output logic     new_access,  // Access waiting
  output smc_req_t pend_req     // The waiting access
);

  //------------------
  // Holding register
  //------------------
  logic     pend_valid;  // Entry occupied
  smc_req_t pend_q;      // Entry payload

  // Occupancy flag
  // A fresh strobe wins over accept, so a request arriving in
  // the same cycle as the take simply refills the entry
  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      pend_valid <= 1'b0;
    end
    else if (req_valid)
    begin
      pend_valid <= 1'b1;  // Load or reload
    end
    else if (accept)
    begin
      pend_valid <= 1'b0;  // Taken and free again
    end
  end

  // Payload register
  always_ff @(posedge sys_clk22)
  begin
    if (req_valid)
    begin
      pend_q <= req;
    end
  end

  //------------------
  // To the state machine
  //------------------
  // Level held until the machine accepts
  assign new_access = pend_valid;
  assign pend_req   = pend_q;  // Only meaningful with new_access

endmodule

//--- source/smc_phase_counters.sv
//------------------
// Phase counters for the access state machine
// Leading-edge, wait-state and trailing-edge down counters,
// plus the latched timing settings of the current access.
// An enable low keeps its counter preloaded, high counts down
//------------------

`timescale 1ns/1ps

module smc_phase_counters
  import smc_pkg::*;
(
  input  logic        sys_clk22,
  input  logic        n_sys_reset22,

  input  smc_timing_t timing,       // Host timing settings
  input  logic        load_timing,  // Store cycle, take settings

  input  logic        le_enable,    // Count leading edge
  input  logic        ws_enable,    // Count wait states
  input  logic        cste_enable,  // Count trailing edge

  output smc_edge_t   csle_count,   // Leading edge cycles left
  output smc_edge_t   cste_count,   // Trailing edge cycles left
  output smc_wait_t   ws_count,     // Wait states left
  output smc_edge_t   csle_store,   // Latched CS leading edge
  output smc_edge_t   oete_store    // Latched OE end setting
);

  smc_edge_t csle_q;
  smc_edge_t cste_q;
  smc_wait_t ws_q;

  // Latched settings, reused for back-to-back accesses
  smc_edge_t csle_st_q;
  smc_edge_t cste_st_q;
  smc_edge_t oete_st_q;
  smc_wait_t ws_st_q;

  // Reload values, fresh settings while they are being stored
  smc_edge_t csle_load;
  smc_edge_t cste_load;
  smc_wait_t ws_load;

  assign csle_load = load_timing ? timing.csle : csle_st_q;
  assign cste_load = load_timing ? timing.cste : cste_st_q;
  assign ws_load   = load_timing ? timing.ws   : ws_st_q;

  //------------------
  // Settings store
  //------------------
  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      csle_st_q <= '0;
      cste_st_q <= '0;
      oete_st_q <= '0;
      ws_st_q   <= '0;
    end
    else if (load_timing)
    begin
      csle_st_q <= timing.csle;
      cste_st_q <= timing.cste;
      oete_st_q <= timing.oete;
      ws_st_q   <= timing.ws;
    end
  end

  //------------------
  // Down counters
  //------------------
  // Enable high decrements and holds at zero, low reloads
  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      csle_q <= '0;
      cste_q <= '0;
      ws_q   <= '0;
    end
    else
    begin
      if (!le_enable)
        csle_q <= csle_load;
      else if (csle_q != 2'd0)
        csle_q <= csle_q - 2'd1;

      if (!ws_enable)
        ws_q <= ws_load;
      else if (ws_q != 8'd0)
        ws_q <= ws_q - 8'd1;

      if (!cste_enable)
        cste_q <= cste_load;
      else if (cste_q != 2'd0)
        cste_q <= cste_q - 2'd1;
    end
  end

  // Store cycle picks LE or RW from the setting being loaded
  assign csle_count = load_timing ? timing.csle : csle_q;
  assign cste_count = cste_q;
  assign ws_count   = ws_q;
  assign csle_store = csle_st_q;
  assign oete_store = oete_st_q;

endmodule

//--- source/smc_pkg.sv
//------------------
// Shared types for the lite static memory controller
// Bus widths, timing settings, host request and response
// records and the one-hot access state encoding
// Modules pull these in with a wildcard import in their header
//------------------

package smc_pkg;

  //------------------
  // Plain vector types
  //------------------
  typedef logic [15:0] smc_addr_t;  // Memory word address
  typedef logic [15:0] smc_data_t;  // Memory data word
  typedef logic [7:0]  smc_wait_t;  // Wait state count
  typedef logic [1:0]  smc_edge_t;  // Edge count, LE/TE/OE end

  //------------------
  // Timing settings
  //------------------
  // Quasi-static, sampled once per access in the store cycle
  typedef struct packed {
    smc_edge_t csle;  // CS cycles before the strobe
    smc_wait_t ws;    // Wait states, strobe is ws+1 cycles
    smc_edge_t cste;  // CS cycles after the strobe
    smc_edge_t oete;  // Last wait counts which no longer latch
  } smc_timing_t;

  // Host side request, one per strobe
  typedef struct packed {
    logic      write;  // 1 = write, 0 = read
    smc_addr_t addr;
    smc_data_t wdata;
  } smc_req_t;

  // Host side response
  typedef struct packed {
    logic      write;  // Direction of the finished access
    smc_data_t rdata;  // Zero for writes
  } smc_rsp_t;

  //------------------
  // Access state machine
  //------------------
  // One-hot, a single flop per state
  typedef enum logic [4:0] {
    st_idle  = 5'b00001,  // Nothing in progress
    st_store = 5'b00010,  // Load access and settings
    st_le    = 5'b00100,  // CS leading edge
    st_rw    = 5'b01000,  // OE or WE active
    st_float = 5'b10000   // CS trailing edge, bus turnaround
  } smc_state_t;

endpackage

//--- source/smc_read_capture.sv
//------------------
// Read data capture and response
// Samples the memory bus through the latch window and returns
// one response per access, a cycle after done
//------------------

`timescale 1ns/1ps

module smc_read_capture
  import smc_pkg::*;
(
  input  logic      sys_clk22,
  input  logic      n_sys_reset22,

  input  logic      latch_data,  // Read data window
  input  logic      smc_done,    // Access finishing
  input  logic      cur_write,   // Direction of that access
  input  smc_data_t mem_rdata,   // From the memory

  output logic      rsp_valid,   // One-cycle response strobe
  output smc_rsp_t  rsp
);

  smc_data_t rdata_q;    // Last sampled read word
  smc_data_t rdata_now;  // Includes a sample in the done cycle

  // Every window cycle overwrites, last sample wins
  always_ff @(posedge sys_clk22)
  begin
    if (latch_data)
      rdata_q <= mem_rdata;
  end

  // Window may close in the done cycle itself
  assign rdata_now = latch_data ? mem_rdata : rdata_q;

  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= smc_done;
  end

  // Writes return zero data
  always_ff @(posedge sys_clk22)
  begin
    if (smc_done)
    begin
      rsp.write <= cur_write;
      rsp.rdata <= cur_write ? '0 : rdata_now;
    end
  end

endmodule

//--- source/smc_state.sv
//------------------
// Access state machine
// Runs each access through store, leading edge, strobe and
// float phases. A waiting access of the same direction is
// chained straight into LE or RW so CS stays low
// Bus strobes are registered from the next state
//------------------

`timescale 1ns/1ps

module smc_state
  import smc_pkg::*;
(
  input  logic      sys_clk22,
  input  logic      n_sys_reset22,

  // From request capture
  input  logic      new_access,
  input  smc_req_t  pend_req,

  // From the phase counters
  input  smc_edge_t csle_count,
  input  smc_edge_t cste_count,
  input  smc_wait_t ws_count,
  input  smc_edge_t csle_store,
  input  smc_edge_t oete_store,

  output logic      accept,       // Waiting access taken
  output logic      load_timing,  // Store cycle
  output logic      le_enable,
  output logic      ws_enable,
  output logic      cste_enable,
  output logic      latch_data,   // Sample read data
  output logic      smc_done,     // Last cycle of an access
  output logic      cur_write,    // Direction of the active access
  output logic      idle,

  // Memory bus
  output logic      mem_cs_n,
  output logic      mem_oe_n,
  output logic      mem_we_n,
  output smc_addr_t mem_addr,
  output smc_data_t mem_wdata
);

  smc_state_t cur_state;
  smc_state_t next_state;
  smc_state_t follow_on;   // Where a finished access goes
  smc_req_t   cur_req;     // Active access
  logic       next_write;  // Direction once the edge is taken
  logic       last_rw;     // Final strobe cycle

  //------------------
  // Decodes
  //------------------
  assign last_rw = (cur_state == st_rw) && (ws_count == 8'd0);

  // Done at strobe end without float, or at the last float cycle
  assign smc_done = (last_rw && (cste_count == 2'd0)) ||
                    ((cur_state == st_float) && (cste_count == 2'd0));

  assign accept      = new_access && ((cur_state == st_idle) || smc_done);
  assign load_timing = (cur_state == st_store);
  assign le_enable   = (cur_state == st_le);
  assign ws_enable   = (cur_state == st_rw) && (ws_count != 8'd0);  // Zero reloads
  assign cste_enable = (next_state == st_float);  // Counts from the last RW cycle
  assign idle        = (cur_state == st_idle) && !new_access;

  // Read data window, late strobe cycles only
  assign latch_data = (cur_state == st_rw) && !cur_req.write &&
                      (ws_count[1:0] >= oete_store) && (ws_count[7:2] == 6'd0);

  //------------------
  // Next state
  //------------------
  // Direction change goes back through store for a fresh setup
  always_comb
  begin
    if (!new_access)
      follow_on = st_idle;
    else if (pend_req.write != cur_req.write)
      follow_on = st_store;
    else if (csle_store != 2'd0)
      follow_on = st_le;
    else
      follow_on = st_rw;
  end

  always_comb
  begin
    next_state = cur_state;  // Hold by default
    unique case (cur_state)
      st_idle:
        if (new_access)
          next_state = st_store;
      st_store:
        next_state = (csle_count != 2'd0) ? st_le : st_rw;
      st_le:
        if (csle_count < 2'd2)
          next_state = st_rw;  // Last LE cycle
      st_rw:
        if (ws_count == 8'd0)
          next_state = (cste_count != 2'd0) ? st_float : follow_on;
      st_float:
        if (cste_count == 2'd0)
          next_state = follow_on;
      default:
        next_state = st_idle;
    endcase
  end

  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
      cur_state <= st_idle;
    else
      cur_state <= next_state;
  end

  //------------------
  // Active access and bus
  //------------------
  always_ff @(posedge sys_clk22)
  begin
    if (accept)
      cur_req <= pend_req;
  end

  assign next_write = accept ? pend_req.write : cur_req.write;

  // Registered strobes, aligned with the state they belong to
  always_ff @(posedge sys_clk22 or negedge n_sys_reset22)
  begin
    if (!n_sys_reset22)
    begin
      mem_cs_n <= 1'b1;
      mem_oe_n <= 1'b1;
      mem_we_n <= 1'b1;
    end
    else
    begin
      mem_cs_n <= !(next_state inside {st_le, st_rw, st_float});
      mem_oe_n <= !((next_state == st_rw) && !next_write);
      mem_we_n <= !((next_state == st_rw) && next_write);
    end
  end

  assign cur_write = cur_req.write;
  assign mem_addr  = cur_req.addr;
  assign mem_wdata = cur_req.wdata;

endmodule

//--- source/smc_top.sv
//------------------
// Lite static memory controller, single chip select
// Host side takes one-cycle request strobes and returns
// one-cycle responses. Memory side is an async SRAM bus
//------------------

`timescale 1ns/1ps

module smc_top
  import smc_pkg::*;
(
  input  logic        sys_clk22,
  input  logic        n_sys_reset22,

  // Host
  input  logic        req_valid,
  input  smc_req_t    req,
  input  smc_timing_t timing,
  output logic        rsp_valid,
  output smc_rsp_t    rsp,
  output logic        idle,

  // Memory bus
  output logic        mem_cs_n,
  output logic        mem_oe_n,
  output logic        mem_we_n,
  output smc_addr_t   mem_addr,
  output smc_data_t   mem_wdata,
  input  smc_data_t   mem_rdata
);

  // Decode to state machine
  logic      new_access;
  logic      accept;
  smc_req_t  pend_req;

  // State machine and counters
  logic      load_timing;
  logic      le_enable;
  logic      ws_enable;
  logic      cste_enable;
  smc_edge_t csle_count;
  smc_edge_t cste_count;
  smc_wait_t ws_count;
  smc_edge_t csle_store;
  smc_edge_t oete_store;

  // State machine to capture
  logic      latch_data;
  logic      smc_done;
  logic      cur_write;

  smc_access_decode u_decode (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .req_valid     (req_valid),
    .req           (req),
    .accept        (accept),
    .new_access    (new_access),
    .pend_req      (pend_req)
  );

  smc_phase_counters u_counters (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .timing        (timing),
    .load_timing   (load_timing),
    .le_enable     (le_enable),
    .ws_enable     (ws_enable),
    .cste_enable   (cste_enable),
    .csle_count    (csle_count),
    .cste_count    (cste_count),
    .ws_count      (ws_count),
    .csle_store    (csle_store),
    .oete_store    (oete_store)
  );

  smc_state u_state (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .new_access    (new_access),
    .pend_req      (pend_req),
    .csle_count    (csle_count),
    .cste_count    (cste_count),
    .ws_count      (ws_count),
    .csle_store    (csle_store),
    .oete_store    (oete_store),
    .accept        (accept),
    .load_timing   (load_timing),
    .le_enable     (le_enable),
    .ws_enable     (ws_enable),
    .cste_enable   (cste_enable),
    .latch_data    (latch_data),
    .smc_done      (smc_done),
    .cur_write     (cur_write),
    .idle          (idle),
    .mem_cs_n      (mem_cs_n),
    .mem_oe_n      (mem_oe_n),
    .mem_we_n      (mem_we_n),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata)
  );

  smc_read_capture u_capture (
    .sys_clk22     (sys_clk22),
    .n_sys_reset22 (n_sys_reset22),
    .latch_data    (latch_data),
    .smc_done      (smc_done),
    .cur_write     (cur_write),
    .mem_rdata     (mem_rdata),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

endmodule
